// File: all.f
+incdir+dv
source/mips_pkg.sv
source/dmem_if.sv
source/alu.sv
source/reg_file.sv
source/branch_unit.sv
source/load_store_align.sv
source/control_decode.sv
source/datapath.sv
source/cpu_top.sv
dv/tb_cpu.sv

// File: dv/tb_ref_model.svh
// program image and expected results of the reference run
word_t      imem [256];
word_t      halt_pc;
int         prog_len = 0;
int         seed = 59931;
word_t      exp_fetch [$];
word_t      exp_st_addr [$];
word_t      exp_st_data [$];
logic [3:0] exp_st_be [$];
word_t      exp_ld_addr [$];

// initial data memory contents, every byte depends on the word index
function automatic word_t fill_word(int idx);
   logic [7:0] a;
   a = idx[7:0];
   return {a, ~a, a ^ 8'h5a, {a[6:0], a[7]}};
endfunction

// be[3] covers bits 31:24, the big-endian offset 0
function automatic word_t merge_bytes(word_t old, word_t data, logic [3:0] be);
   word_t res;
   res = old;
   for (int i = 0; i < 4; i++) begin
      if (be[i])
         res[8*i +: 8] = data[8*i +: 8];
   end
   return res;
endfunction

function automatic word_t enc_r(funct_e fn, int rs, int rt, int rd, int sh);
   return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
endfunction

function automatic word_t enc_i(opcode_e op, int rs, int rt, int imm);
   return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

function automatic word_t enc_j(opcode_e op, int word_idx);
   return {op, 26'(word_idx)};
endfunction

function automatic void emit(word_t ins);
   imem[prog_len] = ins;
   prog_len++;
endfunction

function automatic int rnd_reg();
   return $unsigned($random(seed)) % 32;
endfunction

function automatic void build_program();
   funct_e  rfn [11] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT,
                         FN_SLTU, FN_SLL, FN_SRL, FN_SRA};
   opcode_e iop [7]  = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
   int      k;
   int      p;
   for (int i = 0; i < 256; i++)
      imem[i] = '0;
   for (int i = 1; i < 32; i++)
      emit(enc_i(OP_ADDIU, 0, i, i * 32'h1357));  // known start values
   emit(enc_i(OP_LUI, 0, 1, 16'h8765));
   emit(enc_i(OP_ORI, 1, 1, 16'h4321));    // back-to-back dependency
   emit(enc_i(OP_ADDIU, 0, 2, 16'h0100));  // data base
   emit(enc_i(OP_SW, 2, 1, 0));            // base just computed
   emit(enc_i(OP_SB, 2, 1, 5));
   emit(enc_i(OP_SH, 2, 1, 10));
   emit(enc_i(OP_SB, 2, 1, 15));
   emit(enc_i(OP_SH, 2, 1, 16));
   emit(enc_i(OP_LB, 2, 3, 0));
   emit(enc_i(OP_SW, 2, 3, 20));           // load then store of it
   emit(enc_i(OP_LBU, 2, 4, 1));
   emit(enc_r(FN_ADDU, 4, 4, 5, 0));       // load-use in the alu
   emit(enc_i(OP_SW, 2, 5, 24));
   emit(enc_i(OP_LH, 0, 6, 16'h0302));     // negative halves
   emit(enc_i(OP_LHU, 0, 7, 16'h0300));
   emit(enc_i(OP_LB, 0, 8, 16'h0041));
   emit(enc_i(OP_LBU, 0, 9, 16'h004d));
   emit(enc_i(OP_LW, 0, 10, 16'h0048));
   emit(enc_i(OP_SW, 2, 6, 28));
   emit(enc_i(OP_ADDIU, 0, 0, 16'h0077));  // r0 stays zero
   emit(enc_i(OP_SW, 2, 0, 32));
   emit(enc_i(OP_BEQ, 0, 0, 2));           // taken
   emit(enc_i(OP_ADDIU, 0, 11, 1));        // delay slot
   emit(enc_i(OP_ADDIU, 0, 11, 2));        // skipped
   emit(enc_i(OP_BNE, 0, 0, 5));           // not taken
   emit(enc_i(OP_ADDIU, 11, 12, 3));
   emit(enc_i(OP_BEQ, 1, 0, 5));           // not taken
   emit(enc_i(OP_ADDIU, 12, 12, 4));
   emit(enc_i(OP_BNE, 1, 0, 2));           // taken
   emit(enc_i(OP_ADDIU, 0, 13, 7));
   emit(enc_i(OP_ADDIU, 0, 13, 9));        // skipped
   p = prog_len;
   emit(enc_j(OP_JAL, p + 4));
   emit(enc_i(OP_ADDIU, 0, 14, 16'h0055));
   emit(enc_j(OP_J, p + 7));               // return point, jumps past the subroutine
   emit(enc_r(FN_ADDU, 31, 0, 15, 0));
   emit(enc_i(OP_SW, 2, 31, 36));          // subroutine, link value
   emit(enc_r(FN_JR, 31, 0, 0, 0));
   emit(enc_i(OP_ADDIU, 14, 16, 16'h0033));
   for (int i = 0; i < 24; i++) begin
      k = $unsigned($random(seed)) % 18;
      if (k < 8)
         emit(enc_r(rfn[k], rnd_reg(), rnd_reg(), rnd_reg(), 0));
      else if (k < 11)
         emit(enc_r(rfn[k], 0, rnd_reg(), rnd_reg(), rnd_reg()));  // shamt field
      else
         emit(enc_i(iop[k - 11], rnd_reg(), rnd_reg(), $random(seed)));
   end
   for (int i = 0; i < 32; i++)
      emit(enc_i(OP_SW, 0, i, 16'h0200 + 4 * i));  // dump all registers
   halt_pc = RESET_PC + 32'(4 * prog_len);
   emit(enc_i(OP_BEQ, 0, 0, 16'hffff));  // spin here
   emit(32'h0000_0000);
endfunction

// instruction-level model, one delay slot, big-endian lanes
function automatic void run_reference();
   word_t      r [32];
   word_t      mem [256];
   word_t      pc;
   word_t      npc;
   word_t      nxt;
   word_t      ins;
   word_t      s;
   word_t      t;
   word_t      simm;
   word_t      ea;
   word_t      w;
   word_t      res;
   word_t      sd;
   logic [3:0] be;
   int         dst;
   int         steps;
   for (int i = 0; i < 256; i++)
      mem[i] = fill_word(i);
   for (int i = 0; i < 32; i++)
      r[i] = '0;
   pc    = RESET_PC;
   npc   = RESET_PC + 32'd4;
   steps = 0;
   while (pc != halt_pc && steps < 4096) begin
      exp_fetch.push_back(pc);
      ins  = imem[pc[9:2]];
      s    = r[ins[25:21]];
      t    = r[ins[20:16]];
      simm = {{16{ins[15]}}, ins[15:0]};
      ea   = s + simm;
      w    = mem[ea[9:2]];
      nxt  = npc + 32'd4;
      dst  = 0;
      res  = '0;
      case (ins[31:26])
         6'h00: begin
            dst = ins[15:11];
            case (ins[5:0])
               6'h21:   res = s + t;
               6'h23:   res = s - t;
               6'h24:   res = s & t;
               6'h25:   res = s | t;
               6'h26:   res = s ^ t;
               6'h27:   res = ~(s | t);
               6'h2a:   res = ($signed(s) < $signed(t)) ? 32'd1 : 32'd0;
               6'h2b:   res = (s < t) ? 32'd1 : 32'd0;
               6'h00:   res = t << ins[10:6];
               6'h02:   res = t >> ins[10:6];
               6'h03:   res = $signed(t) >>> ins[10:6];
               6'h08: begin
                  nxt = s;  // jr
                  dst = 0;
               end
               default: dst = 0;
            endcase
         end
         6'h02: nxt = {npc[31:28], ins[25:0], 2'b00};
         6'h03: begin
            nxt = {npc[31:28], ins[25:0], 2'b00};
            res = pc + 32'd8;  // skips the delay slot
            dst = 31;
         end
         6'h04: nxt = (s == t) ? npc + (simm << 2) : nxt;
         6'h05: nxt = (s != t) ? npc + (simm << 2) : nxt;
         6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
            dst = ins[20:16];
            case (ins[28:26])
               3'd1:    res = s + simm;
               3'd2:    res = ($signed(s) < $signed(simm)) ? 32'd1 : 32'd0;
               3'd3:    res = (s < simm) ? 32'd1 : 32'd0;
               3'd4:    res = s & {16'h0, ins[15:0]};
               3'd5:    res = s | {16'h0, ins[15:0]};
               3'd6:    res = s ^ {16'h0, ins[15:0]};
               default: res = {ins[15:0], 16'h0};
            endcase
         end
         6'h20, 6'h21, 6'h23, 6'h24, 6'h25: begin
            dst = ins[20:16];
            exp_ld_addr.push_back(ea);
            case (ins[27:26])
               2'b00: begin
                  res = (w >> (8 * (3 - ea[1:0]))) & 32'h0000_00ff;
                  res = ins[28] ? res : {{24{res[7]}}, res[7:0]};
               end
               2'b01: begin
                  res = (w >> (16 * (1 - ea[1]))) & 32'h0000_ffff;
                  res = ins[28] ? res : {{16{res[15]}}, res[15:0]};
               end
               default: res = w;
            endcase
         end
         6'h28, 6'h29, 6'h2b: begin
            case (ins[27:26])
               2'b00: begin
                  be = 4'b0001 << (3 - ea[1:0]);
                  sd = {24'h0, t[7:0]} << (8 * (3 - ea[1:0]));
               end
               2'b01: begin
                  be = ea[1] ? 4'b0011 : 4'b1100;
                  sd = {16'h0, t[15:0]} << (16 * (1 - ea[1]));
               end
               default: begin
                  be = 4'b1111;
                  sd = t;
               end
            endcase
            exp_st_addr.push_back(ea);
            exp_st_data.push_back(sd);
            exp_st_be.push_back(be);
            mem[ea[9:2]] = merge_bytes(w, sd, be);
         end
         default: dst = 0;  // anything else is a nop
      endcase
      if (dst != 0)
         r[dst] = res;
      pc  = npc;
      npc = nxt;
      steps++;
   end
   exp_fetch.push_back(pc);  // first fetch of the spin loop
endfunction

// File: dv/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
   import mips_pkg::*;

   localparam word_t RESET_PC     = 32'h0000_0000;
   localparam int    RESET_CYCLES = 16;
   localparam int    CLK_PERIOD   = 40;

   logic       CLK = 1'b0;
   logic       rst = 1'b1;
   word_t      imem_addr;
   word_t      imem_rdata = '0;
   word_t      dmem_addr;
   word_t      dmem_wdata;
   logic [3:0] dmem_be;
   logic       dmem_we;
   logic       dmem_re;
   word_t      dmem_rdata = '0;
   word_t      dmem [256];
   int         fetch_idx = 0;
   int         store_idx = 0;
   int         load_idx = 0;
   logic       rst_prev = 1'b1;  // rst seen at the previous falling edge
   bit         built = 1'b0;

   `include "tb_ref_model.svh"

   cpu_top #(.RESET_PC(RESET_PC)) dut_i (
      .CLK        (CLK),
      .rst        (rst),
      .imem_addr  (imem_addr),
      .imem_rdata (imem_rdata),
      .dmem_addr  (dmem_addr),
      .dmem_wdata (dmem_wdata),
      .dmem_be    (dmem_be),
      .dmem_we    (dmem_we),
      .dmem_re    (dmem_re),
      .dmem_rdata (dmem_rdata)
   );

   initial begin
      forever #(CLK_PERIOD / 2) CLK = ~CLK;
   end

   task automatic stop_run(string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1);
   endtask

   task automatic check_fetch(word_t exp_addr);
      if (imem_addr !== exp_addr)
         stop_run($sformatf("FAIL imem_addr expected %h got %h", exp_addr, imem_addr));
   endtask

   task automatic check_load(word_t exp_addr);
      if (dmem_addr !== exp_addr)
         stop_run($sformatf("FAIL dmem_addr expected %h got %h", exp_addr, dmem_addr));
   endtask

   // lanes outside be are don't care
   task automatic check_store(word_t exp_addr, word_t exp_data, logic [3:0] exp_be);
      word_t mask;
      mask = {{8{exp_be[3]}}, {8{exp_be[2]}}, {8{exp_be[1]}}, {8{exp_be[0]}}};
      if (dmem_addr !== exp_addr)
         stop_run($sformatf("FAIL dmem_addr expected %h got %h", exp_addr, dmem_addr));
      else if (dmem_be !== exp_be)
         stop_run($sformatf("FAIL dmem_be expected %h got %h", exp_be, dmem_be));
      else if ((dmem_wdata & mask) !== (exp_data & mask))
         stop_run($sformatf("FAIL dmem_wdata expected %h got %h", exp_data & mask,
                            dmem_wdata & mask));
   endtask

   // one-cycle registered memories
   always @(posedge CLK) begin
      imem_rdata <= imem[imem_addr[9:2]];
      dmem_rdata <= dmem[dmem_addr[9:2]];
      if (dmem_we)
         dmem[dmem_addr[9:2]] <= merge_bytes(dmem[dmem_addr[9:2]], dmem_wdata, dmem_be);
   end

   // outputs are settled at the falling edge
   always @(negedge CLK) begin
      if ((rst || rst_prev) && (dmem_we || dmem_re)) begin
         stop_run("data memory strobe active during reset");
      end else if (!rst) begin
         if (fetch_idx < exp_fetch.size()) begin
            check_fetch(exp_fetch[fetch_idx]);
            fetch_idx++;
         end
         if (dmem_we) begin
            if (store_idx >= exp_st_addr.size())
               stop_run("store strobe seen after the last expected store");
            else begin
               check_store(exp_st_addr[store_idx], exp_st_data[store_idx],
                           exp_st_be[store_idx]);
               store_idx++;
            end
         end
         if (dmem_re) begin
            if (load_idx >= exp_ld_addr.size())
               stop_run("load strobe seen after the last expected load");
            else begin
               check_load(exp_ld_addr[load_idx]);
               load_idx++;
            end
         end
      end
      rst_prev = rst;
   end

   initial begin
      for (int i = 0; i < 256; i++)
         dmem[i] = fill_word(i);
      build_program();
      run_reference();
      built = 1'b1;
      repeat (RESET_CYCLES) @(posedge CLK);
      rst <= 1'b0;
      wait (store_idx == exp_st_addr.size() && load_idx == exp_ld_addr.size() &&
            fetch_idx == exp_fetch.size());
      @(posedge CLK);
      $display("TB PASSED");
      $finish;
   end

   // four cycles per executed instruction plus reset
   initial begin
      wait (built);
      #((RESET_CYCLES + 4 * exp_fetch.size()) * CLK_PERIOD);
      stop_run($sformatf("timeout, only %0d of %0d expected stores and %0d of %0d loads appeared",
                         store_idx, exp_st_addr.size(), load_idx, exp_ld_addr.size()));
   end

endmodule

// File: run_sim.sh
#!/bin/sh
# builds the cpu testbench with Verilator, runs it and scans the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_cpu -o sim_tb_cpu

./obj_dir/sim_tb_cpu 2>&1 | tee sim.log

if grep -q "TB FAILED" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
echo "simulation finished without failure"

// File: source/alu.sv
`timescale 1ns/1ps

module alu (
   input  mips_pkg::word_t   a,
   input  mips_pkg::word_t   b,
   input  mips_pkg::alu_op_e op,
   output mips_pkg::word_t   y
);
   import mips_pkg::*;

   logic [4:0] shamt;

   assign shamt = a[4:0];  // shamt field or rs, chosen upstream

   always_comb begin
      case (op)
         ALU_ADD:  y = a + b;
         ALU_SUB:  y = a - b;
         ALU_AND:  y = a & b;
         ALU_OR:   y = a | b;
         ALU_XOR:  y = a ^ b;
         ALU_NOR:  y = ~(a | b);
         ALU_SLT:  y = {31'b0, $signed(a) < $signed(b)};
         ALU_SLTU: y = {31'b0, a < b};
         ALU_SLL:  y = b << shamt;
         ALU_SRL:  y = b >> shamt;
         ALU_SRA:  y = word_t'($signed(b) >>> shamt);
         ALU_LUI:  y = {b[15:0], 16'h0000};
         default:  y = '0;
      endcase
   end

endmodule

// File: source/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
   input  mips_pkg::flow_e flow,
   input  mips_pkg::word_t rs_val,
   input  mips_pkg::word_t rt_val,
   input  mips_pkg::word_t pc_ex,
   input  logic [15:0]     imm,
   input  logic [25:0]     jtarget,
   output logic            taken,
   output mips_pkg::word_t target
);
   import mips_pkg::*;

   word_t pc_plus4;

   assign pc_plus4 = pc_ex + 32'd4;  // delay slot address

   always_comb begin
      taken  = 1'b0;
      target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
      case (flow)
         FLOW_BEQ: taken = (rs_val == rt_val);
         FLOW_BNE: taken = (rs_val != rt_val);
         FLOW_J: begin
            taken  = 1'b1;
            target = {pc_plus4[31:28], jtarget, 2'b00};  // same 256 MB region
         end
         FLOW_JR: begin
            taken  = 1'b1;
            target = rs_val;
         end
         default: taken = 1'b0;
      endcase
   end

endmodule

// File: source/control_decode.sv
`timescale 1ns/1ps

module control_decode (
   input  mips_pkg::word_t instr,
   output mips_pkg::ctrl_t ctrl
);
   import mips_pkg::*;

   opcode_e opcode;
   funct_e  funct;

   assign opcode = opcode_e'(instr[31:26]);
   assign funct  = funct_e'(instr[5:0]);

   always_comb begin
      // nop unless a known encoding says otherwise
      ctrl.alu_op     = ALU_ADD;
      ctrl.src_a      = SRC_A_REG;
      ctrl.src_b      = SRC_B_IMM;
      ctrl.reg_dst    = DST_RT;
      ctrl.flow       = FLOW_NONE;
      ctrl.reg_write  = 1'b0;
      ctrl.imm_signed = 1'b1;
      ctrl.mem_read   = 1'b0;
      ctrl.mem_write  = 1'b0;
      ctrl.mem_size   = MEM_WORD;
      ctrl.mem_signed = 1'b0;
      ctrl.link       = 1'b0;
      case (opcode)
         OP_RTYPE: begin
            ctrl.src_b     = SRC_B_REG;
            ctrl.reg_dst   = DST_RD;
            ctrl.reg_write = 1'b1;
            case (funct)
               FN_ADDU: ctrl.alu_op = ALU_ADD;
               FN_SUBU: ctrl.alu_op = ALU_SUB;
               FN_AND:  ctrl.alu_op = ALU_AND;
               FN_OR:   ctrl.alu_op = ALU_OR;
               FN_XOR:  ctrl.alu_op = ALU_XOR;
               FN_NOR:  ctrl.alu_op = ALU_NOR;
               FN_SLT:  ctrl.alu_op = ALU_SLT;
               FN_SLTU: ctrl.alu_op = ALU_SLTU;
               FN_SLL:  ctrl.alu_op = ALU_SLL;
               FN_SRL:  ctrl.alu_op = ALU_SRL;
               FN_SRA:  ctrl.alu_op = ALU_SRA;
               FN_JR: begin
                  ctrl.flow      = FLOW_JR;
                  ctrl.reg_write = 1'b0;
               end
               default: ctrl.reg_write = 1'b0;  // unknown funct
            endcase
            if (instr[5:2] == 4'b0000)
               ctrl.src_a = SRC_A_SHAMT;  // SLL/SRL/SRA
         end
         OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
            ctrl.reg_write  = 1'b1;
            ctrl.imm_signed = ~instr[28];  // logic ops zero extend
            case (opcode)
               OP_SLTI:  ctrl.alu_op = ALU_SLT;
               OP_SLTIU: ctrl.alu_op = ALU_SLTU;
               OP_ANDI:  ctrl.alu_op = ALU_AND;
               OP_ORI:   ctrl.alu_op = ALU_OR;
               OP_XORI:  ctrl.alu_op = ALU_XOR;
               OP_LUI:   ctrl.alu_op = ALU_LUI;
               default:  ctrl.alu_op = ALU_ADD;
            endcase
         end
         OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
            ctrl.mem_read   = 1'b1;
            ctrl.reg_write  = 1'b1;
            ctrl.mem_size   = mem_size_e'(instr[27:26]);
            ctrl.mem_signed = ~instr[28];  // LBU/LHU set bit 28
         end
         OP_SB, OP_SH, OP_SW: begin
            ctrl.mem_write = 1'b1;
            ctrl.mem_size  = mem_size_e'(instr[27:26]);
         end
         OP_BEQ: ctrl.flow = FLOW_BEQ;
         OP_BNE: ctrl.flow = FLOW_BNE;
         OP_J:   ctrl.flow = FLOW_J;
         OP_JAL: begin
            ctrl.flow      = FLOW_J;
            ctrl.link      = 1'b1;
            ctrl.src_b     = SRC_B_EIGHT;  // pc_ex + 8
            ctrl.reg_dst   = DST_R31;
            ctrl.reg_write = 1'b1;
         end
         default: ctrl.flow = FLOW_NONE;
      endcase
   end

endmodule

// File: source/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
   parameter mips_pkg::word_t RESET_PC = 32'h0000_0000
) (
   input  logic            CLK,
   input  logic            rst,
   output mips_pkg::word_t imem_addr,
   input  mips_pkg::word_t imem_rdata,
   output mips_pkg::word_t dmem_addr,
   output mips_pkg::word_t dmem_wdata,
   output logic [3:0]      dmem_be,
   output logic            dmem_we,
   output logic            dmem_re,
   input  mips_pkg::word_t dmem_rdata
);
   import mips_pkg::*;

   word_t instr;  // execute-stage instruction
   ctrl_t ctrl;

   dmem_if dmem_bus (.CLK(CLK), .rst(rst));

   control_decode decode_i (.instr(instr), .ctrl(ctrl));

   datapath #(.RESET_PC(RESET_PC)) datapath_i (
      .CLK        (CLK),
      .rst        (rst),
      .imem_addr  (imem_addr),
      .imem_rdata (imem_rdata),
      .instr      (instr),
      .ctrl       (ctrl),
      .dmem       (dmem_bus.master)
   );

   assign dmem_addr      = dmem_bus.addr;
   assign dmem_wdata     = dmem_bus.wdata;
   assign dmem_be        = dmem_bus.be;
   assign dmem_we        = dmem_bus.we;
   assign dmem_re        = dmem_bus.re;
   assign dmem_bus.rdata = dmem_rdata;  // registered read in the memory

endmodule

// File: source/datapath.sv
`timescale 1ns/1ps

module datapath #(
   parameter mips_pkg::word_t RESET_PC = 32'h0000_0000
) (
   input  logic            CLK,
   input  logic            rst,
   output mips_pkg::word_t imem_addr,
   input  mips_pkg::word_t imem_rdata,
   output mips_pkg::word_t instr,
   input  mips_pkg::ctrl_t ctrl,
   dmem_if.master          dmem
);
   import mips_pkg::*;

   word_t      pc;        // fetch address
   word_t      pc_ex;     // address of instr in execute
   logic       rst_q;
   reg_addr_t  rs;
   reg_addr_t  rt;
   reg_addr_t  dest;
   word_t      rd1;
   word_t      rd2;
   word_t      rs_val;
   word_t      rt_val;
   word_t      imm_ext;
   word_t      op_a;
   word_t      op_b;
   word_t      alu_y;
   word_t      br_target;
   logic       br_taken;
   word_t      st_wdata;
   logic [3:0] st_be;
   word_t      ld_data;
   word_t      wb_value;

   // writeback stage
   logic       wb_we;
   logic       wb_load;
   reg_addr_t  wb_dest;
   word_t      wb_alu;
   mem_size_e  wb_size;
   logic       wb_signed;

   assign imem_addr = pc;
   assign instr     = (rst || rst_q) ? '0 : imem_rdata;  // nop until first real fetch returns

   assign rs = instr[25:21];
   assign rt = instr[20:16];

   always_comb begin
      case (ctrl.reg_dst)
         DST_RD:  dest = instr[15:11];
         DST_R31: dest = 5'd31;
         default: dest = instr[20:16];
      endcase
   end

   reg_file regs_i (
      .CLK (CLK),
      .we  (wb_we),
      .ra1 (rs),
      .ra2 (rt),
      .wa  (wb_dest),
      .wd  (wb_value),
      .rd1 (rd1),
      .rd2 (rd2)
   );

   // writeback value bypasses the register file, covers load-use too
   assign wb_value = wb_load ? ld_data : wb_alu;
   assign rs_val   = (wb_we && wb_dest != 5'd0 && wb_dest == rs) ? wb_value : rd1;
   assign rt_val   = (wb_we && wb_dest != 5'd0 && wb_dest == rt) ? wb_value : rd2;

   assign imm_ext = ctrl.imm_signed ? {{16{instr[15]}}, instr[15:0]} : {16'b0, instr[15:0]};

   always_comb begin
      if (ctrl.link)
         op_a = pc_ex;
      else if (ctrl.src_a == SRC_A_SHAMT)
         op_a = {27'b0, instr[10:6]};
      else
         op_a = rs_val;
      case (ctrl.src_b)
         SRC_B_IMM:   op_b = imm_ext;
         SRC_B_EIGHT: op_b = 32'd8;
         default:     op_b = rt_val;
      endcase
   end

   alu alu_i (.a(op_a), .b(op_b), .op(ctrl.alu_op), .y(alu_y));

   branch_unit branch_i (
      .flow    (ctrl.flow),
      .rs_val  (rs_val),
      .rt_val  (rt_val),
      .pc_ex   (pc_ex),
      .imm     (instr[15:0]),
      .jtarget (instr[25:0]),
      .taken   (br_taken),
      .target  (br_target)
   );

   load_store_align align_i (
      .st_data   (rt_val),
      .st_size   (ctrl.mem_size),
      .st_offset (alu_y[1:0]),
      .wdata     (st_wdata),
      .be        (st_be),
      .ld_raw    (dmem.rdata),
      .ld_size   (wb_size),
      .ld_signed (wb_signed),
      .ld_offset (wb_alu[1:0]),
      .ld_data   (ld_data)
   );

   assign dmem.addr  = alu_y;
   assign dmem.wdata = st_wdata;
   assign dmem.be    = ctrl.mem_write ? st_be : 4'b0000;
   assign dmem.we    = ctrl.mem_write;
   assign dmem.re    = ctrl.mem_read;

   always_ff @(posedge CLK) begin
      if (rst) begin
         pc      <= RESET_PC;
         wb_we   <= 1'b0;
         wb_load <= 1'b0;
      end else begin
         pc      <= br_taken ? br_target : pc + 32'd4;  // delay slot already fetched
         wb_we   <= ctrl.reg_write;
         wb_load <= ctrl.mem_read;
      end
   end

   always_ff @(posedge CLK) begin
      rst_q     <= rst;
      pc_ex     <= pc;
      wb_dest   <= dest;
      wb_alu    <= alu_y;
      wb_size   <= ctrl.mem_size;
      wb_signed <= ctrl.mem_signed;
   end

   a_rw_exclusive: assert property (@(posedge CLK) disable iff (rst) !(dmem.we && dmem.re))
      else $error("dmem we and re together");

endmodule

// File: source/dmem_if.sv
`timescale 1ns/1ps

interface dmem_if (
   input logic CLK,
   input logic rst
);
   import mips_pkg::*;

   word_t      addr;
   word_t      wdata;
   logic [3:0] be;
   logic       we;     // single-cycle strobe
   logic       re;     // single-cycle strobe
   word_t      rdata;  // valid one cycle after re

   modport master (output addr, wdata, be, we, re, input rdata);
   modport mem    (input addr, wdata, be, we, re, output rdata);

   a_be_idle: assert property (@(posedge CLK) disable iff (rst) !we |-> be == 4'b0000)
      else $error("dmem be active without we");

endinterface

// File: source/load_store_align.sv
`timescale 1ns/1ps

module load_store_align (
   input  mips_pkg::word_t     st_data,
   input  mips_pkg::mem_size_e st_size,
   input  logic [1:0]          st_offset,
   output mips_pkg::word_t     wdata,
   output logic [3:0]          be,
   input  mips_pkg::word_t     ld_raw,
   input  mips_pkg::mem_size_e ld_size,
   input  logic                ld_signed,
   input  logic [1:0]          ld_offset,
   output mips_pkg::word_t     ld_data
);
   import mips_pkg::*;

   word_t       ld_shifted;
   logic [7:0]  byte_lane;
   logic [15:0] half_lane;

   // big-endian, offset 0 is bits 31:24, so shift by 8*(3-offset)
   always_comb begin
      case (st_size)
         MEM_BYTE: begin
            wdata = {24'b0, st_data[7:0]} << {~st_offset, 3'b000};
            be    = 4'b1000 >> st_offset;
         end
         MEM_HALF: begin
            wdata = st_offset[1] ? {16'b0, st_data[15:0]} : {st_data[15:0], 16'b0};
            be    = st_offset[1] ? 4'b0011 : 4'b1100;
         end
         default: begin
            wdata = st_data;
            be    = 4'b1111;
         end
      endcase
   end

   assign ld_shifted = ld_raw >> {~ld_offset, 3'b000};
   assign byte_lane  = ld_shifted[7:0];
   assign half_lane  = ld_offset[1] ? ld_raw[15:0] : ld_raw[31:16];

   always_comb begin
      case (ld_size)
         MEM_BYTE: ld_data = {{24{ld_signed & byte_lane[7]}}, byte_lane};
         MEM_HALF: ld_data = {{16{ld_signed & half_lane[15]}}, half_lane};
         default:  ld_data = ld_raw;
      endcase
   end

   always_comb begin
      a_half_aligned: assert final (!(st_size === MEM_HALF && st_offset[0] === 1'b1) &&
                                    !(ld_size === MEM_HALF && ld_offset[0] === 1'b1))
         else $error("halfword access at odd offset");
   end

endmodule

// File: source/mips_pkg.sv
package mips_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;

   // primary opcodes, instr[31:26]
   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00, OP_J     = 6'h02, OP_JAL  = 6'h03, OP_BEQ   = 6'h04,
      OP_BNE   = 6'h05, OP_ADDIU = 6'h09, OP_SLTI = 6'h0a, OP_SLTIU = 6'h0b,
      OP_ANDI  = 6'h0c, OP_ORI   = 6'h0d, OP_XORI = 6'h0e, OP_LUI   = 6'h0f,
      OP_LB    = 6'h20, OP_LH    = 6'h21, OP_LW   = 6'h23, OP_LBU   = 6'h24,
      OP_LHU   = 6'h25, OP_SB    = 6'h28, OP_SH   = 6'h29, OP_SW    = 6'h2b
   } opcode_e;

   // r-type function codes, instr[5:0]
   typedef enum logic [5:0] {
      FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA = 6'h03, FN_JR   = 6'h08,
      FN_ADDU = 6'h21, FN_SUBU = 6'h23, FN_AND = 6'h24, FN_OR   = 6'h25,
      FN_XOR  = 6'h26, FN_NOR  = 6'h27, FN_SLT = 6'h2a, FN_SLTU = 6'h2b
   } funct_e;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
      ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
   } alu_op_e;

   // matches opcode bits 27:26 of the load/store group
   typedef enum logic [1:0] {MEM_BYTE = 2'b00, MEM_HALF = 2'b01, MEM_WORD = 2'b11} mem_size_e;

   typedef enum logic       {SRC_A_REG, SRC_A_SHAMT} src_a_e;
   typedef enum logic [1:0] {SRC_B_REG, SRC_B_IMM, SRC_B_EIGHT} src_b_e;
   typedef enum logic [1:0] {DST_RT, DST_RD, DST_R31} reg_dst_e;
   typedef enum logic [2:0] {FLOW_NONE, FLOW_BEQ, FLOW_BNE, FLOW_J, FLOW_JR} flow_e;

   typedef struct packed {
      alu_op_e   alu_op;
      src_a_e    src_a;
      src_b_e    src_b;
      reg_dst_e  reg_dst;
      flow_e     flow;
      logic      reg_write;
      logic      imm_signed;  // sign or zero extend imm16
      logic      mem_read;
      logic      mem_write;
      mem_size_e mem_size;
      logic      mem_signed;  // LB/LH
      logic      link;        // operand a from pc_ex
   } ctrl_t;

endpackage

// File: source/reg_file.sv
`timescale 1ns/1ps

module reg_file (
   input  logic                CLK,
   input  logic                we,
   input  mips_pkg::reg_addr_t ra1,
   input  mips_pkg::reg_addr_t ra2,
   input  mips_pkg::reg_addr_t wa,
   input  mips_pkg::word_t     wd,
   output mips_pkg::word_t     rd1,
   output mips_pkg::word_t     rd2
);
   import mips_pkg::*;

   word_t regs [32];

   always_ff @(posedge CLK) begin
      if (we && wa != 5'd0)
         regs[wa] <= wd;
   end

   // $zero reads zero whatever the array holds
   assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
   assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

   a_wa_known: assert property (@(posedge CLK) we |-> !$isunknown(wa))
      else $error("register write to unknown address");

endmodule
